/* hdl/bus_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
  input  mac_map_pkg::addr_t  cpu_addr,
  input  mac_map_pkg::data_t  cpu_dout,
  input  logic                cpu_rw,     // 1 read, 0 write
  input  logic                cpu_uds_n,
  input  logic                cpu_as_n,
  input  logic                overlaid,
  input  mac_map_pkg::data_t  ram_dout,
  input  mac_map_pkg::data_t  rom_dout,
  input  via_pkg::via_byte_t  via_rdata,
  output mac_map_pkg::data_t  cpu_din,
  output logic                vpa_n,
  output logic                ram_cs,
  output logic                rom_cs,
  output mac_map_pkg::addr_t  ram_addr,
  via_bus_if.master           via
);
  import mac_map_pkg::*;

  localparam addr_t ram_base_word = ram_boot_base[23:1];  // As word address

  region_e region;
  logic    periph;  // Peripheral space, reads zero unless VIA

  // ====================================================================
  // Region decode
  // ====================================================================
  always_comb begin
    region = rgn_other;
    casez (cpu_addr[23:20])
      4'b00??: region = rgn_low_mem;
      4'b0100: region = rgn_rom;
      4'b0101: if (cpu_addr[19:12] == scsi_page) region = rgn_scsi;
      4'b0110: region = rgn_ram_hi;
      4'b10?1: region = rgn_scc;
      4'b1101: region = rgn_iwm;
      4'b1110: region = rgn_via;
      default: region = rgn_other;
    endcase
  end

  // Overlay moves RAM down to zero
  always_comb begin
    ram_cs = 1'b0;
    rom_cs = 1'b0;
    case (region)
      rgn_low_mem: begin
        if (overlaid) ram_cs = 1'b1;
        else          rom_cs = 1'b1;  // Boot vectors from ROM
      end
      rgn_rom:    rom_cs = 1'b1;
      rgn_ram_hi: ram_cs = !overlaid;  // Nothing here after overlay
      default: ;
    endcase
  end

  assign ram_addr = overlaid ? cpu_addr : cpu_addr - ram_base_word;

  assign vpa_n  = cpu_as_n | ~cpu_addr[23];  // Autovector, VIA cycles
  assign periph = cpu_addr[23] | (region == rgn_scsi);

  // ====================================================================
  // VIA access
  // ====================================================================
  assign via.sel   = ~cpu_as_n & ~cpu_uds_n & (region == rgn_via);
  assign via.rs    = via_pkg::via_rs_e'(cpu_addr[12:9]);
  assign via.wr    = ~cpu_as_n & ~cpu_rw;
  assign via.rd    = ~cpu_as_n &  cpu_rw;
  assign via.wdata = cpu_dout[15:8];  // Upper lane only

  // Read data toward the CPU
  always_comb begin
    if (via.sel && via.rd)
      cpu_din = {via_rdata, via_rdata};  // Same byte on both lanes
    else if (periph)
      cpu_din = '0;                      // SCSI, SCC, IWM and the rest
    else if (ram_cs)
      cpu_din = ram_dout;
    else
      cpu_din = rom_dout;
  end

endmodule

`default_nettype wire

/* hdl/mac_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_glue #(
  parameter int vblanks_per_second = 60,
  parameter int prescale_bits      = 5
) (
  input  logic               clk_cpu,
  input  logic               reset,
  // CPU bus
  input  mac_map_pkg::addr_t cpu_addr,
  input  mac_map_pkg::data_t cpu_dout,
  input  logic               cpu_rw,
  input  logic               cpu_uds_n,
  input  logic               cpu_as_n,
  output mac_map_pkg::data_t cpu_din,
  output logic               vpa_n,
  // Memories
  input  mac_map_pkg::data_t ram_dout,
  input  mac_map_pkg::data_t rom_dout,
  output logic               ram_cs,
  output logic               rom_cs,
  output mac_map_pkg::addr_t ram_addr,
  // VIA pins
  input  logic               vsync,
  input  logic               hsync,
  input  logic               rtc_data,
  output logic               irq_n,
  output logic [2:0]         audio,
  output via_pkg::via_byte_t port_b
);
  import via_pkg::*;

  via_byte_t   via_rdata;
  logic        overlaid;
  via_flags_t  ier;
  via_flags_t  ifr;
  logic        sr_written;
  logic [15:0] t2_count;
  logic        t2_expire;

  via_bus_if via_bus ();

  // ====================================================================
  // Address decode and data mux
  // ====================================================================
  bus_decode i_bus_decode (
    .cpu_addr  (cpu_addr),
    .cpu_dout  (cpu_dout),
    .cpu_rw    (cpu_rw),
    .cpu_uds_n (cpu_uds_n),
    .cpu_as_n  (cpu_as_n),
    .overlaid  (overlaid),
    .ram_dout  (ram_dout),
    .rom_dout  (rom_dout),
    .via_rdata (via_rdata),
    .cpu_din   (cpu_din),
    .vpa_n     (vpa_n),
    .ram_cs    (ram_cs),
    .rom_cs    (rom_cs),
    .ram_addr  (ram_addr),
    .via       (via_bus)
  );

  // ====================================================================
  // VIA
  // ====================================================================
  via_regs i_via_regs (
    .clk_cpu    (clk_cpu),
    .reset      (reset),
    .via        (via_bus),
    .hsync      (hsync),
    .rtc_data   (rtc_data),
    .ifr        (ifr),
    .t2_count   (t2_count),
    .via_rdata  (via_rdata),
    .overlaid   (overlaid),
    .ier        (ier),
    .sr_mode    (),          // Used inside for the SR strobe
    .sr_written (sr_written),
    .audio      (audio),
    .port_b     (port_b)
  );

  via_timer2 #(
    .prescale_bits (prescale_bits)
  ) i_via_timer2 (
    .clk_cpu   (clk_cpu),
    .reset     (reset),
    .via       (via_bus),
    .t2_count  (t2_count),
    .t2_expire (t2_expire)
  );

  via_irq #(
    .vblanks_per_second (vblanks_per_second)
  ) i_via_irq (
    .clk_cpu    (clk_cpu),
    .reset      (reset),
    .via        (via_bus),
    .vsync      (vsync),
    .ier        (ier),
    .sr_written (sr_written),
    .t2_expire  (t2_expire),
    .ifr        (ifr),
    .irq_n      (irq_n)
  );

endmodule

`default_nettype wire

/* hdl/mac_map_pkg.sv */
`default_nettype none

package mac_map_pkg;

  // ====================================================================
  // CPU bus shape
  // ====================================================================
  localparam int addr_msb   = 23;  // A23 is the top address line
  localparam int addr_lsb   = 1;   // 68000 has no A0
  localparam int data_width = 16;

  typedef logic [addr_msb:addr_lsb] addr_t;  // Word address, 23 bits
  typedef logic [data_width-1:0]    data_t;

  // ====================================================================
  // Memory map
  // ====================================================================
  // Regions picked by A23..A20
  typedef enum logic [2:0] {
    rgn_low_mem = 3'd0,  // 0x000000..0x3fffff, ROM or RAM by overlay
    rgn_rom     = 3'd1,  // 0x400000
    rgn_scsi    = 3'd2,  // 0x580000 page only
    rgn_ram_hi  = 3'd3,  // 0x600000, RAM while overlay is off
    rgn_scc     = 3'd4,
    rgn_iwm     = 3'd5,
    rgn_via     = 3'd6,  // 0xe80000 block
    rgn_other   = 3'd7
  } region_e;

  localparam logic [23:0] ram_boot_base = 24'h600000;  // RAM at boot
  localparam logic [7:0]  scsi_page     = 8'h80;       // A19..A12 for SCSI

endpackage

`default_nettype wire

/* hdl/via_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One decoded VIA access, upper byte lane only
interface via_bus_if;
  import via_pkg::*;

  logic      sel;    // VIA chip select, AS and UDS already qualified
  via_rs_e   rs;     // A12..A9
  logic      wr;     // Bus write cycle
  logic      rd;     // Bus read cycle
  via_byte_t wdata;  // D15..D8

  modport master (
    output sel, rs, wr, rd, wdata
  );

  modport slave (
    input sel, rs, wr, rd, wdata
  );

endinterface

`default_nettype wire

/* hdl/via_irq.sv */
`timescale 1ns/1ps
`default_nettype none

module via_irq #(
  parameter int vblanks_per_second = 60
) (
  input  logic                clk_cpu,
  input  logic                reset,
  via_bus_if.slave            via,
  input  logic                vsync,
  input  via_pkg::via_flags_t ier,
  input  logic                sr_written,
  input  logic                t2_expire,
  output via_pkg::via_flags_t ifr,
  output logic                irq_n
);
  import via_pkg::*;

  localparam int cnt_w = $clog2(vblanks_per_second + 1);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(vblanks_per_second - 1);

  logic             vsync_q;    // Sampled vsync
  logic             vsync_qq;   // Previous sample
  logic             vsync_fall;
  logic [cnt_w-1:0] vblank_cnt;
  logic             wr_en;
  logic             rd_en;
  via_flags_t       set_bits;
  via_flags_t       clr_bits;

  assign wr_en = via.sel & via.wr;
  assign rd_en = via.sel & via.rd;

  // ====================================================================
  // Vertical blank and one second
  // ====================================================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      vsync_q    <= 1'b0;
      vsync_qq   <= 1'b0;
      vblank_cnt <= '0;
    end else begin
      vsync_q  <= vsync;
      vsync_qq <= vsync_q;
      if (vsync_fall) begin
        if (vblank_cnt == cnt_last) vblank_cnt <= '0;
        else                        vblank_cnt <= vblank_cnt + 1'b1;
      end
    end
  end

  assign vsync_fall = vsync_qq & ~vsync_q;

  // Flag sources and clears, set wins
  always_comb begin
    set_bits = '0;
    clr_bits = '0;
    set_bits[int_kbd_ready] = sr_written;
    set_bits[int_t2]        = t2_expire;
    set_bits[int_vblank]    = vsync_fall;
    set_bits[int_onesec]    = vsync_fall & (vblank_cnt == cnt_last);
    if (wr_en) begin
      case (via.rs)
        rs_ifr:    clr_bits = via.wdata[6:0];  // Write 1 to clear
        rs_t2c_hi: clr_bits[int_t2] = 1'b1;
        default: ;
      endcase
    end
    if (rd_en) begin
      case (via.rs)
        rs_orb: begin
          clr_bits[int_kbd_clk] = 1'b1;
          clr_bits[int_kbd_bit] = 1'b1;
        end
        rs_t2c_lo: clr_bits[int_t2]        = 1'b1;
        rs_sr:     clr_bits[int_kbd_ready] = 1'b1;
        rs_ora: begin
          clr_bits[int_onesec] = 1'b1;
          clr_bits[int_vblank] = 1'b1;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (reset) ifr <= '0;
    else       ifr <= (ifr & ~clr_bits) | set_bits;
  end

  assign irq_n = ~|(ifr & ier);  // Level, active low

endmodule

`default_nettype wire

/* hdl/via_pkg.sv */
`default_nettype none

package via_pkg;

  typedef logic [7:0] via_byte_t;
  typedef logic [6:0] via_flags_t;  // IFR and IER without bit 7

  // Register select, A12..A9
  typedef enum logic [3:0] {
    rs_orb    = 4'h0,
    rs_ora_hs = 4'h1,  // ORA with handshake, unused here
    rs_ddrb   = 4'h2,
    rs_ddra   = 4'h3,
    rs_t1c_lo = 4'h4,
    rs_t1c_hi = 4'h5,
    rs_t1l_lo = 4'h6,
    rs_t1l_hi = 4'h7,
    rs_t2c_lo = 4'h8,
    rs_t2c_hi = 4'h9,
    rs_sr     = 4'ha,
    rs_acr    = 4'hb,
    rs_pcr    = 4'hc,
    rs_ifr    = 4'hd,
    rs_ier    = 4'he,
    rs_ora    = 4'hf
  } via_rs_e;

  // Bit positions inside IFR and IER
  typedef enum logic [2:0] {
    int_onesec    = 3'd0,
    int_vblank    = 3'd1,
    int_kbd_ready = 3'd2,
    int_kbd_bit   = 3'd3,
    int_kbd_clk   = 3'd4,
    int_t2        = 3'd5,
    int_t1        = 3'd6
  } int_bit_e;

  // ACR bits 4..2, shift register control
  typedef enum logic [2:0] {
    shift_off      = 3'b000,
    shift_in_t2    = 3'b001,
    shift_in_phi2  = 3'b010,
    shift_in_ext   = 3'b011,  // Keyboard to host
    shift_out_free = 3'b100,
    shift_out_t2   = 3'b101,
    shift_out_phi2 = 3'b110,
    shift_out_ext  = 3'b111   // Host to keyboard
  } sr_mode_e;

  localparam via_byte_t porta_reset = 8'h7f;  // Overlay bit 4 high
  localparam via_byte_t portb_reset = 8'hff;

endpackage

`default_nettype wire

/* hdl/via_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module via_regs (
  input  logic                clk_cpu,
  input  logic                reset,
  via_bus_if.slave            via,
  input  logic                hsync,
  input  logic                rtc_data,
  input  via_pkg::via_flags_t ifr,
  input  logic [15:0]         t2_count,
  output via_pkg::via_byte_t  via_rdata,
  output logic                overlaid,
  output via_pkg::via_flags_t ier,
  output via_pkg::sr_mode_e   sr_mode,
  output logic                sr_written,   // Pulse toward kbd_ready
  output logic [2:0]          audio,
  output via_pkg::via_byte_t  port_b
);
  import via_pkg::*;

  via_byte_t   orb;        // Port B output
  via_byte_t   ora;        // Port A output
  logic        ddrb0;      // Direction of PB0, RTC data line
  via_byte_t   acr;
  via_byte_t   sr;         // Keyboard shift register
  logic [15:0] t1_count;   // Timer 1 holds values only
  logic [15:0] t1_latch;
  logic        wr_en;

  assign wr_en = via.sel & via.wr;

  // ====================================================================
  // Register writes
  // ====================================================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      orb      <= portb_reset;
      ora      <= porta_reset;
      ddrb0    <= 1'b1;
      acr      <= '0;
      ier      <= '0;
      overlaid <= 1'b0;
    end else if (wr_en) begin
      case (via.rs)
        rs_orb:  orb   <= via.wdata;
        rs_ddrb: ddrb0 <= via.wdata[0];
        rs_acr:  acr   <= via.wdata;
        rs_ier: begin
          if (via.wdata[7]) ier <= ier |  via.wdata[6:0];  // Bit 7 set
          else              ier <= ier & ~via.wdata[6:0];  // Bit 7 clear
        end
        rs_ora: begin
          ora <= via.wdata;
          if (!via.wdata[4]) overlaid <= 1'b1;  // Sticky until reset
        end
        default: ;
      endcase
    end
  end

  // Timer 1 and shift data
  always_ff @(posedge clk_cpu) begin
    if (wr_en) begin
      case (via.rs)
        rs_t1c_lo: t1_count[7:0]  <= via.wdata;
        rs_t1c_hi: t1_count[15:8] <= via.wdata;
        rs_t1l_lo: t1_latch[7:0]  <= via.wdata;
        rs_t1l_hi: t1_latch[15:8] <= via.wdata;
        rs_sr:     sr             <= via.wdata;
        default: ;
      endcase
    end
  end

  assign sr_mode    = sr_mode_e'(acr[4:2]);
  assign sr_written = wr_en & (via.rs == rs_sr) & (sr_mode == shift_out_ext);

  assign audio  = ora[2:0];  // Sound volume
  assign port_b = orb;

  // ====================================================================
  // Read mux
  // ====================================================================
  always_comb begin
    case (via.rs)
      // Mouse X2, Y2 and button idle high
      rs_orb:    via_rdata = {orb[7], ~hsync, 3'b111, orb[2:1],
                              ddrb0 ? orb[0] : rtc_data};
      rs_ddrb:   via_rdata = {7'b1000011, ddrb0};
      rs_ddra:   via_rdata = 8'h7f;
      rs_t1c_lo: via_rdata = t1_count[7:0];
      rs_t1c_hi: via_rdata = t1_count[15:8];
      rs_t1l_lo: via_rdata = t1_latch[7:0];
      rs_t1l_hi: via_rdata = t1_latch[15:8];
      rs_t2c_lo: via_rdata = t2_count[7:0];
      rs_t2c_hi: via_rdata = t2_count[15:8];
      rs_sr:     via_rdata = sr;
      rs_acr:    via_rdata = acr;
      rs_pcr:    via_rdata = 8'h00;
      rs_ifr:    via_rdata = {|(ifr & ier), ifr};  // Top bit is any enabled
      rs_ier:    via_rdata = {1'b0, ier};
      rs_ora:    via_rdata = {1'b0, ora[6:0]};
      default:   via_rdata = 8'hbe;                // Open bus pattern
    endcase
  end

endmodule

`default_nettype wire

/* hdl/via_timer2.sv */
`timescale 1ns/1ps
`default_nettype none

module via_timer2 #(
  parameter int prescale_bits = 5  // Tick every 2**n clocks
) (
  input  logic        clk_cpu,
  input  logic        reset,
  via_bus_if.slave    via,
  output logic [15:0] t2_count,
  output logic        t2_expire   // One clock wide
);
  import via_pkg::*;

  logic [prescale_bits-1:0] prescale;
  logic                     tick;
  logic                     armed;
  via_byte_t                latch_lo;
  logic                     load_lo;
  logic                     load_hi;

  assign load_lo = via.sel & via.wr & (via.rs == rs_t2c_lo);
  assign load_hi = via.sel & via.wr & (via.rs == rs_t2c_hi);

  // Free-running divider, roughly the VIA E clock
  always_ff @(posedge clk_cpu) begin
    if (reset) prescale <= '0;
    else       prescale <= prescale + 1'b1;
  end

  assign tick = (prescale == '0);

  always_ff @(posedge clk_cpu) begin
    if (load_lo) latch_lo <= via.wdata;
  end

  // ====================================================================
  // Countdown
  // ====================================================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      t2_count  <= '0;
      armed     <= 1'b0;
      t2_expire <= 1'b0;
    end else begin
      t2_expire <= 1'b0;
      if (load_hi) begin
        t2_count <= {via.wdata, latch_lo};  // High write starts the timer
        armed    <= 1'b1;
      end else if (armed && tick) begin
        if (t2_count == '0) begin
          armed     <= 1'b0;                // One shot
          t2_expire <= 1'b1;
        end else begin
          t2_count <= t2_count - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the mac_glue testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mac_glue -f sources.f -o Vtb_mac_glue

./obj_dir/Vtb_mac_glue 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

/* sim/mac_glue_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_glue_checker (
  input logic clk_cpu,
  input logic reset,
  input logic irq_n,
  input logic overlaid,
  input logic ram_cs,
  input logic rom_cs
);

  // ====================================================================
  // Reset and overlay
  // ====================================================================
  // Flags and IER cleared by the first reset edge
  a_irq_in_reset: assert property (@(posedge clk_cpu) reset && $past(reset) |-> irq_n)
    else $error("irq_n low while reset is held");

  // Overlay bit is sticky
  a_overlay_sticky: assert property (@(posedge clk_cpu)
    !reset && !$past(reset) |-> !$fell(overlaid))
    else $error("overlaid fell without reset");

  // ====================================================================
  // Chip selects
  // ====================================================================
  a_one_select: assert property (@(posedge clk_cpu) !(ram_cs && rom_cs))
    else $error("ram_cs and rom_cs high together");

endmodule

bind mac_glue mac_glue_checker i_mac_glue_checker (
  .clk_cpu  (clk_cpu),
  .reset    (reset),
  .irq_n    (irq_n),
  .overlaid (overlaid),   // Internal net of the top level
  .ram_cs   (ram_cs),
  .rom_cs   (rom_cs)
);

`default_nettype wire

/* sim/tb_mac_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mac_glue;
  import mac_map_pkg::*;
  import via_pkg::*;

  localparam logic [23:0] via_base   = 24'hefe1fe;  // A12..A9 left zero for rs
  localparam int          poll_limit = 400;         // Polls before a wait gives up

  logic       clk_cpu = 1'b0;
  logic       reset;
  addr_t      cpu_addr;
  data_t      cpu_dout;
  logic       cpu_rw;
  logic       cpu_uds_n;
  logic       cpu_as_n;
  data_t      cpu_din;
  logic       vpa_n;
  data_t      ram_dout;
  data_t      rom_dout;
  logic       ram_cs;
  logic       rom_cs;
  addr_t      ram_addr;
  logic       vsync;
  logic       hsync;
  logic       rtc_data;
  logic       irq_n;
  logic [2:0] audio;
  via_byte_t  port_b;

  // ====================================================================
  // Register model
  // ====================================================================
  via_byte_t   orb_m;
  via_byte_t   ora_m;
  via_byte_t   acr_m;
  via_byte_t   sr_m;
  logic        ddrb0_m;
  via_flags_t  ier_m;
  via_flags_t  ifr_m;
  logic [15:0] t1c_m;
  logic [15:0] t1l_m;
  logic [15:0] t2_m;      // Only known once the timer has expired
  logic        overlaid_m;

  // Outputs seen in the last bus read
  logic  seen_ram_cs;
  logic  seen_rom_cs;
  logic  seen_vpa_n;
  addr_t seen_ram_addr;

  // Pending checks for the compare process
  string       name_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] act_q[$];
  event        check_ev;
  string       chk_name;
  logic [31:0] chk_exp;
  logic [31:0] chk_act;

  int    checks = 0;
  int    errors = 0;        // Wrong values
  int    faults = 0;        // Timeouts
  int    tests_run = 0;
  int    tests_failed = 0;
  int    errors_at_start;
  string test_name;

  mac_glue #(
    .vblanks_per_second (60),
    .prescale_bits      (5)
  ) i_mac_glue (
    .clk_cpu   (clk_cpu),
    .reset     (reset),
    .cpu_addr  (cpu_addr),
    .cpu_dout  (cpu_dout),
    .cpu_rw    (cpu_rw),
    .cpu_uds_n (cpu_uds_n),
    .cpu_as_n  (cpu_as_n),
    .cpu_din   (cpu_din),
    .vpa_n     (vpa_n),
    .ram_dout  (ram_dout),
    .rom_dout  (rom_dout),
    .ram_cs    (ram_cs),
    .rom_cs    (rom_cs),
    .ram_addr  (ram_addr),
    .vsync     (vsync),
    .hsync     (hsync),
    .rtc_data  (rtc_data),
    .irq_n     (irq_n),
    .audio     (audio),
    .port_b    (port_b)
  );

  always #5 clk_cpu = ~clk_cpu;  // 100 MHz

  // ====================================================================
  // Reference model
  // ====================================================================
  function automatic logic [23:0] via_addr(via_rs_e rs);
    return via_base | {11'h0, rs, 9'h0};
  endfunction

  function automatic via_byte_t via_model_read(via_rs_e rs);
    via_byte_t b;
    case (rs)
      rs_orb:    b = {orb_m[7], ~hsync, 3'b111, orb_m[2:1],
                      ddrb0_m ? orb_m[0] : rtc_data};  // Mouse bits idle
      rs_t1c_lo: b = t1c_m[7:0];
      rs_t1c_hi: b = t1c_m[15:8];
      rs_t1l_lo: b = t1l_m[7:0];
      rs_t1l_hi: b = t1l_m[15:8];
      rs_t2c_lo: b = t2_m[7:0];
      rs_t2c_hi: b = t2_m[15:8];
      rs_sr:     b = sr_m;
      rs_acr:    b = acr_m;
      rs_ifr:    b = {|(ifr_m & ier_m), ifr_m};
      rs_ier:    b = {1'b0, ier_m};
      rs_ora:    b = {1'b0, ora_m[6:0]};
      default:   b = 8'hbe;
    endcase
    return b;
  endfunction

  // Data toward the CPU for a read at a byte address
  function automatic data_t bus_model_read(logic [23:0] baddr);
    via_byte_t b;
    data_t     d;
    b = via_model_read(via_rs_e'(baddr[12:9]));
    if (baddr[23:20] == 4'he)       d = {b, b};
    else if (baddr[23])             d = '0;        // SCC, IWM and above
    else if (baddr[23:22] == 2'b00) d = overlaid_m ? ram_dout : rom_dout;
    else if (baddr[23:20] == 4'h6)  d = overlaid_m ? rom_dout : ram_dout;
    else                            d = rom_dout;
    return d;
  endfunction

  function automatic logic [1:0] cs_model(logic [23:0] baddr);  // {ram, rom}
    if (baddr[23:22] == 2'b00) return overlaid_m ? 2'b10 : 2'b01;
    if (baddr[23:20] == 4'h4)  return 2'b01;
    if (baddr[23:20] == 4'h6)  return overlaid_m ? 2'b00 : 2'b10;
    return 2'b00;
  endfunction

  function automatic addr_t ram_addr_model(logic [23:0] baddr);
    logic [23:0] offset;
    offset = overlaid_m ? baddr : baddr - ram_boot_base;
    return offset[23:1];
  endfunction

  function automatic void model_write(via_rs_e rs, via_byte_t b);
    case (rs)
      rs_orb:    orb_m = b;
      rs_ddrb:   ddrb0_m = b[0];
      rs_t1c_lo: t1c_m[7:0] = b;
      rs_t1c_hi: t1c_m[15:8] = b;
      rs_t1l_lo: t1l_m[7:0] = b;
      rs_t1l_hi: t1l_m[15:8] = b;
      rs_t2c_hi: ifr_m[int_t2] = 1'b0;
      rs_sr: begin
        sr_m = b;
        if (acr_m[4:2] == shift_out_ext) ifr_m[int_kbd_ready] = 1'b1;
      end
      rs_acr:    acr_m = b;
      rs_ifr:    ifr_m = ifr_m & ~b[6:0];
      rs_ier:    ier_m = b[7] ? (ier_m | b[6:0]) : (ier_m & ~b[6:0]);
      rs_ora: begin
        ora_m = b;
        if (!b[4]) overlaid_m = 1'b1;
      end
      default: ;
    endcase
  endfunction

  function automatic void model_read_clear(via_rs_e rs);
    case (rs)
      rs_orb: begin
        ifr_m[int_kbd_clk] = 1'b0;
        ifr_m[int_kbd_bit] = 1'b0;
      end
      rs_t2c_lo: ifr_m[int_t2] = 1'b0;
      rs_sr:     ifr_m[int_kbd_ready] = 1'b0;
      rs_ora: begin
        ifr_m[int_onesec] = 1'b0;
        ifr_m[int_vblank] = 1'b0;
      end
      default: ;
    endcase
  endfunction

  // ====================================================================
  // Compare process
  // ====================================================================
  always @(check_ev) begin
    while (exp_q.size() > 0) begin
      chk_name = name_q.pop_front();
      chk_exp  = exp_q.pop_front();
      chk_act  = act_q.pop_front();
      checks++;
      if (chk_act !== chk_exp) begin
        errors++;
        $display("CHECK FAILED %s: expected %h, actual %h", chk_name, chk_exp, chk_act);
      end
    end
  end

  task automatic push_check(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    name_q.push_back({test_name, ": ", name});
    exp_q.push_back(exp);
    act_q.push_back(act);
    -> check_ev;
  endtask

  // ====================================================================
  // Bus tasks
  // ====================================================================
  task automatic bus_read(input logic [23:0] baddr, output data_t d);
    @(posedge clk_cpu);
    cpu_addr  <= baddr[23:1];
    cpu_rw    <= 1'b1;
    cpu_uds_n <= 1'b0;
    cpu_as_n  <= 1'b0;
    @(negedge clk_cpu);                    // Mid cycle with outputs settled
    d             = cpu_din;
    seen_ram_cs   = ram_cs;
    seen_rom_cs   = rom_cs;
    seen_vpa_n    = vpa_n;
    seen_ram_addr = ram_addr;
    @(posedge clk_cpu);
    cpu_as_n  <= 1'b1;
    cpu_uds_n <= 1'b1;
  endtask

  task automatic bus_write(input logic [23:0] baddr, input data_t d);
    @(posedge clk_cpu);
    cpu_addr  <= baddr[23:1];
    cpu_dout  <= d;
    cpu_rw    <= 1'b0;
    cpu_uds_n <= 1'b0;
    cpu_as_n  <= 1'b0;
    @(posedge clk_cpu);                    // Write lands on this edge
    cpu_as_n  <= 1'b1;
    cpu_uds_n <= 1'b1;
    cpu_rw    <= 1'b1;
  endtask

  task automatic via_write(input via_rs_e rs, input via_byte_t b);
    bus_write(via_addr(rs), {b, 8'h00});
    model_write(rs, b);
  endtask

  task automatic via_check(input string name, input via_rs_e rs);
    data_t d;
    bus_read(via_addr(rs), d);
    push_check(name, {16'h0, bus_model_read(via_addr(rs))}, {16'h0, d});
    model_read_clear(rs);
  endtask

  // Memory side read with chip selects, offset and VPA
  task automatic mem_check(input string name, input logic [23:0] baddr);
    data_t d;
    bus_read(baddr, d);
    push_check({name, " data"}, {16'h0, bus_model_read(baddr)}, {16'h0, d});
    push_check({name, " selects"}, {30'h0, cs_model(baddr)},
               {30'h0, seen_ram_cs, seen_rom_cs});
    push_check({name, " vpa_n"}, {31'h0, ~baddr[23]}, {31'h0, seen_vpa_n});
    if (cs_model(baddr) == 2'b10)
      push_check({name, " ram_addr"}, {9'h0, ram_addr_model(baddr)},
                 {9'h0, seen_ram_addr});
  endtask

  // Sound volume from PA2..PA0 and the port B pins
  task automatic port_check(input string name);
    @(negedge clk_cpu);
    push_check({name, " audio"}, {29'h0, ora_m[2:0]}, {29'h0, audio});
    push_check({name, " port_b"}, {24'h0, orb_m}, {24'h0, port_b});
  endtask

  task automatic irq_check(input string name);
    @(negedge clk_cpu);
    push_check(name, {31'h0, ~|(ifr_m & ier_m)}, {31'h0, irq_n});
  endtask

  task automatic wait_ifr_bit(input int_bit_e pos, input string what);
    data_t d;
    int    n;
    d = '0;
    n = 0;
    while (d[8 + pos] !== 1'b1 && n < poll_limit) begin
      bus_read(via_addr(rs_ifr), d);
      n++;
    end
    if (d[8 + pos] !== 1'b1) begin
      $display("%s: timed out waiting for %s", test_name, what);
      faults++;
    end
  endtask

  task automatic wait_irq_low(input string what);
    int n;
    n = 0;
    while (irq_n !== 1'b0 && n < poll_limit) begin
      @(negedge clk_cpu);
      n++;
    end
    if (irq_n !== 1'b0) begin
      $display("%s: timed out waiting for %s", test_name, what);
      faults++;
    end
  endtask

  task automatic vsync_pulse();
    @(posedge clk_cpu);
    vsync <= 1'b1;
    repeat (3) @(posedge clk_cpu);
    vsync <= 1'b0;                         // Falling edge is the event
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors + faults;
  endtask

  task automatic finish_test();
    @(posedge clk_cpu);                    // Let pending compares drain
    tests_run++;
    if (errors + faults == errors_at_start) begin
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name,
               errors + faults - errors_at_start);
    end
  endtask

  // Watchdog for the whole run
  initial begin
    repeat (200000) @(posedge clk_cpu);
    $display("simulation timed out before the last test finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ====================================================================
  // Stimulus
  // ====================================================================
  initial begin
    via_byte_t b;
    int        i;
    void'($urandom(12));
    reset     = 1'b1;
    cpu_addr  = '0;
    cpu_dout  = '0;
    cpu_rw    = 1'b1;
    cpu_uds_n = 1'b1;
    cpu_as_n  = 1'b1;
    vsync     = 1'b0;
    hsync     = 1'b1;
    rtc_data  = 1'b0;
    ram_dout  = 16'($urandom());
    rom_dout  = 16'($urandom());
    orb_m      = portb_reset;
    ora_m      = porta_reset;
    acr_m      = '0;
    sr_m       = '0;
    ddrb0_m    = 1'b1;
    ier_m      = '0;
    ifr_m      = '0;
    t1c_m      = '0;
    t1l_m      = '0;
    t2_m       = '0;
    overlaid_m = 1'b0;
    repeat (8) @(posedge clk_cpu);
    reset <= 1'b0;

    start_test("overlay map");
    mem_check("boot rom at zero", 24'h000000);
    mem_check("boot ram high", 24'h600010);
    b = 8'($urandom()) & 8'hef;           // Bit 4 low drops the overlay
    via_write(rs_ora, b);
    port_check("ora pins");
    mem_check("ram at zero", 24'h000100);
    mem_check("rom still high", 24'h400000);
    finish_test();

    start_test("register readback");
    via_write(rs_orb, 8'($urandom()));
    port_check("orb pins out");
    via_check("orb", rs_orb);
    via_write(rs_ddrb, 8'h00);            // PB0 now follows the RTC pin
    @(posedge clk_cpu);
    hsync    <= 1'b0;
    rtc_data <= 1'b1;
    via_check("orb pins", rs_orb);
    via_write(rs_ddrb, 8'h01);
    via_write(rs_acr, 8'($urandom()));
    via_check("acr", rs_acr);
    via_write(rs_t1c_lo, 8'($urandom()));
    via_write(rs_t1c_hi, 8'($urandom()));
    via_write(rs_t1l_lo, 8'($urandom()));
    via_write(rs_t1l_hi, 8'($urandom()));
    via_check("t1c_lo", rs_t1c_lo);
    via_check("t1c_hi", rs_t1c_hi);
    via_check("t1l_lo", rs_t1l_lo);
    via_check("t1l_hi", rs_t1l_hi);
    via_write(rs_ier, 8'($urandom()) | 8'h80);
    via_check("ier set", rs_ier);
    via_write(rs_ier, 8'($urandom()) & 8'h7f);
    via_check("ier clear", rs_ier);
    mem_check("scc", 24'h9ffff8);
    mem_check("iwm", 24'hdfe1fe);
    finish_test();

    start_test("vertical blank");
    for (i = 1; i <= 60; i++) begin
      vsync_pulse();
      wait_ifr_bit(int_vblank, "vblank flag");
      ifr_m[int_vblank] = 1'b1;
      if (i == 60) ifr_m[int_onesec] = 1'b1;  // Once per 60 frames
      via_check($sformatf("ifr after pulse %0d", i), rs_ifr);
      if (i < 60) via_write(rs_ifr, 8'h02);
    end
    via_check("ora read", rs_ora);
    via_check("ifr after ora read", rs_ifr);
    finish_test();

    start_test("timer 2");
    b = 8'(3 + $urandom_range(0, 9));
    via_write(rs_t2c_lo, b);
    via_write(rs_t2c_hi, 8'h00);          // Starts the countdown
    wait_ifr_bit(int_t2, "timer 2 flag");
    ifr_m[int_t2] = 1'b1;
    t2_m = '0;
    via_check("t2 flag set", rs_ifr);
    via_check("t2 count at zero", rs_t2c_lo);
    via_check("t2 flag cleared", rs_ifr);
    finish_test();

    start_test("interrupt request");
    via_write(rs_ier, 8'h7f);
    via_write(rs_ier, 8'h82);             // Only vblank enabled
    irq_check("irq idle");
    vsync_pulse();
    wait_irq_low("irq_n after vsync");
    ifr_m[int_vblank] = 1'b1;
    via_check("ifr on vblank", rs_ifr);
    via_write(rs_ifr, 8'h02);
    irq_check("irq after ifr clear");
    vsync_pulse();
    wait_irq_low("irq_n after second vsync");
    ifr_m[int_vblank] = 1'b1;
    via_write(rs_ier, 8'h02);             // Mask while the flag stays
    irq_check("irq masked");
    via_check("ifr while masked", rs_ifr);
    via_write(rs_ifr, 8'h7f);
    finish_test();

    start_test("shift register");
    via_write(rs_acr, (8'($urandom()) & 8'he3) | 8'h1c);  // Shift out on ext clock
    via_check("acr shift out", rs_acr);
    via_write(rs_sr, 8'($urandom()));
    via_check("kbd_ready set", rs_ifr);
    via_check("sr readback", rs_sr);
    via_check("kbd_ready cleared", rs_ifr);
    finish_test();

    @(posedge clk_cpu);
    $display("tests %0d, failed %0d, checks %0d, errors %0d, timeouts %0d",
             tests_run, tests_failed, checks, errors, faults);
    if (errors == 0 && faults == 0 && tests_failed == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
hdl/mac_map_pkg.sv
hdl/via_pkg.sv
hdl/via_bus_if.sv
hdl/bus_decode.sv
hdl/via_regs.sv
hdl/via_timer2.sv
hdl/via_irq.sv
hdl/mac_glue.sv
sim/mac_glue_checker.sv
sim/tb_mac_glue.sv
